//--- Makefile
VERILATOR ?= verilator
TOP       ?= ramtest_tb
FILELIST  ?= ramtest_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/ramtest_pkg.sv
`default_nettype none

package ramtest_pkg;

	// ------------------------------------------------
	// Data path
	// ------------------------------------------------
	localparam int DATA_W = 32; // Host and memory word width

	// ------------------------------------------------
	// Memory command channel
	// ------------------------------------------------
	// Burst length field carries length minus one, as on the MIG port
	localparam int BL_W = 6;

	// Opcodes follow the low bits of the MIG instruction field
	typedef enum logic [1:0] {
		MEM_WRITE = 2'b00,
		MEM_READ  = 2'b01
	} mem_op_t;

endpackage

`default_nettype wire

//--- dma/dma_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dma_ctrl
	import ramtest_pkg::*;
#(
	parameter int FIFO_DEPTH = 64,
	parameter int BURST      = 8,
	parameter int MEM_WORDS  = 256,
	parameter int CMD_DEPTH  = 4
) (
	input  wire logic                             okClk,
	input  wire logic                             rst,
	input  wire logic                             soft_rst,
	input  wire logic                             reads_en,
	input  wire logic                             writes_en,
	input  wire logic [$clog2(FIFO_DEPTH+1)-1:0]  ib_count,
	input  wire logic [DATA_W-1:0]                ib_data,
	output logic                                  ib_read,
	input  wire logic                             po_read,
	output logic                                  cmd_en,
	output mem_op_t                               cmd_op,
	output logic      [$clog2(MEM_WORDS)-1:0]     cmd_addr,
	output logic      [BL_W-1:0]                  cmd_bl,
	input  wire logic                             cmd_done,
	output logic                                  wr_en,
	output logic      [DATA_W-1:0]                wr_data
);

	localparam int ADDR_W = $clog2(MEM_WORDS);
	localparam int OC_W   = $clog2(FIFO_DEPTH+1);
	localparam int CC_W   = $clog2(CMD_DEPTH+1);
	localparam int SC_W   = $clog2(MEM_WORDS+1);

	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_WRITE = 2'd1;
	localparam logic [1:0] ST_READ  = 2'd2;

	logic [1:0]        state;
	logic [BL_W-1:0]   beat;
	logic              last_write;   // Alternation between writes and reads
	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] rd_addr;
	logic [CC_W-1:0]   cmd_credits;
	logic [OC_W-1:0]   out_credits;  // Free pipe-out words not yet promised
	logic [SC_W-1:0]   stored;       // Words in memory awaiting read
	logic              can_write;
	logic              can_read;
	logic              wr_issue;
	logic              rd_issue;

	assign can_write = writes_en && (int'(ib_count) >= BURST) && (cmd_credits != '0) &&
		(int'(stored) <= MEM_WORDS - BURST);
	assign can_read = reads_en && (int'(stored) >= BURST) && (cmd_credits != '0) &&
		(int'(out_credits) >= BURST);

	// ------------------------------------------------
	// Outputs decoded from state
	// ------------------------------------------------
	assign ib_read  = (state == ST_WRITE);
	assign wr_en    = ib_read;          // Pipe-in head goes straight to the write queue
	assign wr_data  = ib_data;
	assign wr_issue = (state == ST_WRITE) && (beat == BL_W'(BURST-1)); // With last data word
	assign rd_issue = (state == ST_READ);
	assign cmd_en   = wr_issue || rd_issue;
	assign cmd_op   = rd_issue ? MEM_READ : MEM_WRITE;
	assign cmd_addr = rd_issue ? rd_addr : wr_addr;
	assign cmd_bl   = BL_W'(BURST-1);

	always_ff @(posedge okClk) begin
		if (rst || soft_rst) begin
			state      <= ST_IDLE;
			beat       <= '0;
			last_write <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					beat <= '0;
					if (can_write && (!can_read || !last_write)) begin
						state <= ST_WRITE;
					end else if (can_read) begin
						state <= ST_READ;
					end
				end
				ST_WRITE: begin
					beat <= beat + 1'b1;
					if (wr_issue) begin
						state      <= ST_IDLE;
						last_write <= 1'b1;
					end
				end
				ST_READ: begin
					state      <= ST_IDLE; // Single command cycle
					last_write <= 1'b0;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ------------------------------------------------
	// Addresses, credits and memory occupancy
	// ------------------------------------------------
	always_ff @(posedge okClk) begin
		if (rst || soft_rst) begin
			wr_addr     <= '0;
			rd_addr     <= '0;
			stored      <= '0;
			cmd_credits <= CC_W'(CMD_DEPTH);
			out_credits <= OC_W'(FIFO_DEPTH);
		end else begin
			if (wr_issue) begin
				wr_addr <= wr_addr + ADDR_W'(BURST); // Wraps with the array size
				stored  <= stored + SC_W'(BURST);
			end else if (rd_issue) begin
				rd_addr <= rd_addr + ADDR_W'(BURST);
				stored  <= stored - SC_W'(BURST);
			end
			cmd_credits <= cmd_credits - CC_W'(cmd_en) + CC_W'(cmd_done);
			out_credits <= out_credits + OC_W'(po_read) - (rd_issue ? OC_W'(BURST) : '0);
		end
	end

	// Returns from mem_port and the host must never outnumber what was spent
	a_credit_bound: assert property (@(posedge okClk) disable iff (rst || soft_rst)
		(int'(cmd_credits) <= CMD_DEPTH) && (int'(out_credits) <= FIFO_DEPTH))
		else $error("dma_ctrl: credit counter above its initial value");

endmodule

`default_nettype wire

//--- dma/mem_port.sv
`timescale 1ns/1ns
`default_nettype none

module mem_port
	import ramtest_pkg::*;
#(
	parameter int BURST     = 8,
	parameter int MEM_WORDS = 256,
	parameter int CMD_DEPTH = 4,
	parameter int READ_LAT  = 3
) (
	input  wire logic                          okClk,
	input  wire logic                          rst,
	input  wire logic                          soft_rst,
	input  wire logic                          cmd_en,
	input  wire mem_op_t                       cmd_op,
	input  wire logic [$clog2(MEM_WORDS)-1:0]  cmd_addr,
	input  wire logic [BL_W-1:0]               cmd_bl,
	output logic                               cmd_done,
	input  wire logic                          wr_en,
	input  wire logic [DATA_W-1:0]             wr_data,
	output logic                               rd_valid,
	output logic      [DATA_W-1:0]             rd_data
);

	localparam int ADDR_W   = $clog2(MEM_WORDS);
	localparam int WQ_DEPTH = CMD_DEPTH * BURST; // Enough for every credited command
	localparam int CQ_PTR_W = $clog2(CMD_DEPTH);
	localparam int CQ_CNT_W = $clog2(CMD_DEPTH+1);
	localparam int WQ_PTR_W = $clog2(WQ_DEPTH);
	localparam int WQ_CNT_W = $clog2(WQ_DEPTH+1);

	// Command queue
	mem_op_t           cq_op   [CMD_DEPTH];
	logic [ADDR_W-1:0] cq_addr [CMD_DEPTH];
	logic [BL_W-1:0]   cq_bl   [CMD_DEPTH];
	logic [CQ_PTR_W-1:0] cq_wr;
	logic [CQ_PTR_W-1:0] cq_rd;
	logic [CQ_CNT_W-1:0] cq_count;
	logic                cq_pop;

	// Write data queue
	logic [DATA_W-1:0]   wq_mem [WQ_DEPTH];
	logic [WQ_PTR_W-1:0] wq_wr;
	logic [WQ_PTR_W-1:0] wq_rd;
	logic [WQ_CNT_W-1:0] wq_count;
	logic                wq_pop;

	// Sequencer and array
	logic [DATA_W-1:0] mem [MEM_WORDS];
	logic              busy;
	mem_op_t           exec_op;
	logic [ADDR_W-1:0] exec_addr;
	logic [BL_W-1:0]   exec_bl;
	logic [BL_W-1:0]   beat;
	logic [READ_LAT-1:0] dl_valid;
	logic [DATA_W-1:0]   dl_data [READ_LAT];

	// Writes wait until the whole burst is in the queue
	assign cq_pop = !busy && (cq_count != '0) &&
		((cq_op[cq_rd] == MEM_READ) || (wq_count > cq_bl[cq_rd]));
	assign wq_pop   = busy && (exec_op == MEM_WRITE);
	assign cmd_done = busy && (beat == exec_bl);
	assign rd_valid = dl_valid[READ_LAT-1];
	assign rd_data  = dl_data[READ_LAT-1];

	// ------------------------------------------------
	// Storage
	// ------------------------------------------------
	always_ff @(posedge okClk) begin
		if (cmd_en) begin
			cq_op[cq_wr]   <= cmd_op;
			cq_addr[cq_wr] <= cmd_addr;
			cq_bl[cq_wr]   <= cmd_bl;
		end
		if (wr_en) begin
			wq_mem[wq_wr] <= wr_data;
		end
		if (wq_pop) begin
			mem[exec_addr] <= wq_mem[wq_rd];
		end
		dl_data[0] <= mem[exec_addr]; // Only marked valid on read beats
		for (int i = 1; i < READ_LAT; i++) begin
			dl_data[i] <= dl_data[i-1];
		end
	end

	// ------------------------------------------------
	// Queue pointers and sequencer
	// ------------------------------------------------
	always_ff @(posedge okClk) begin
		if (rst || soft_rst) begin
			cq_wr     <= '0;
			cq_rd     <= '0;
			cq_count  <= '0;
			wq_wr     <= '0;
			wq_rd     <= '0;
			wq_count  <= '0;
			busy      <= 1'b0;
			exec_op   <= MEM_WRITE;
			exec_addr <= '0;
			exec_bl   <= '0;
			beat      <= '0;
			dl_valid  <= '0;
		end else begin
			if (cmd_en) begin
				cq_wr <= (cq_wr == CQ_PTR_W'(CMD_DEPTH-1)) ? '0 : cq_wr + 1'b1;
			end
			if (wr_en) begin
				wq_wr <= (wq_wr == WQ_PTR_W'(WQ_DEPTH-1)) ? '0 : wq_wr + 1'b1;
			end
			if (wq_pop) begin
				wq_rd <= (wq_rd == WQ_PTR_W'(WQ_DEPTH-1)) ? '0 : wq_rd + 1'b1;
			end
			cq_count <= cq_count + CQ_CNT_W'(cmd_en) - CQ_CNT_W'(cq_pop);
			wq_count <= wq_count + WQ_CNT_W'(wr_en) - WQ_CNT_W'(wq_pop);

			if (cq_pop) begin // Load next command
				cq_rd     <= (cq_rd == CQ_PTR_W'(CMD_DEPTH-1)) ? '0 : cq_rd + 1'b1;
				busy      <= 1'b1;
				exec_op   <= cq_op[cq_rd];
				exec_addr <= cq_addr[cq_rd];
				exec_bl   <= cq_bl[cq_rd];
				beat      <= '0;
			end else if (busy) begin
				exec_addr <= exec_addr + 1'b1;
				beat      <= beat + 1'b1;
				if (cmd_done) begin
					busy <= 1'b0;
				end
			end

			dl_valid <= {dl_valid[READ_LAT-2:0], busy && (exec_op == MEM_READ)};
		end
	end

	// The DMA command credits must keep the queue from filling
	a_cmd_not_full: assert property (@(posedge okClk) disable iff (rst || soft_rst)
		cmd_en |-> (cq_count != CQ_CNT_W'(CMD_DEPTH)))
		else $error("mem_port: command issued with queue full");

endmodule

`default_nettype wire

//--- ramtest_top.f
common/ramtest_pkg.sv
source/block_fifo.sv
source/pipe_throttle.sv
dma/dma_ctrl.sv
dma/mem_port.sv
source/ramtest_top.sv
tests/ramtest_tb.sv

//--- source/block_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module block_fifo
	import ramtest_pkg::*;
#(
	parameter int DEPTH = 64
) (
	input  wire logic                           okClk,
	input  wire logic                           rst,
	input  wire logic                           soft_rst,
	input  wire logic                           write,
	input  wire logic [DATA_W-1:0]              wdata,
	input  wire logic                           read,
	output logic      [DATA_W-1:0]              rdata,
	output logic      [$clog2(DEPTH+1)-1:0]     count,
	output logic                                empty
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH+1);

	logic [DATA_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;

	// Head word is always presented, so the reader sees data with read
	assign rdata = mem[rd_ptr];
	assign empty = (count == '0);

	always_ff @(posedge okClk) begin
		if (write) begin
			mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge okClk) begin
		if (rst || soft_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (write) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			end
			if (read) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(write) - CNT_W'(read); // New word counted next cycle
		end
	end

	// ------------------------------------------------
	// Protocol checks on both sides
	// ------------------------------------------------
	// The host and the DMA credits are what keep these from firing
	a_no_overflow: assert property (@(posedge okClk) disable iff (rst || soft_rst)
		!(write && count == CNT_W'(DEPTH)))
		else $error("block_fifo: write while full");

	a_no_underflow: assert property (@(posedge okClk) disable iff (rst || soft_rst)
		!(read && empty))
		else $error("block_fifo: read while empty");

endmodule

`default_nettype wire

//--- source/pipe_throttle.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_throttle #(
	parameter int FIFO_DEPTH = 64,
	parameter int BLOCK      = 16,
	parameter int HEADROOM   = 4
) (
	input  wire logic                             okClk,
	input  wire logic                             rst,
	input  wire logic                             soft_rst,
	input  wire logic [$clog2(FIFO_DEPTH+1)-1:0]  pi_count,
	input  wire logic [$clog2(FIFO_DEPTH+1)-1:0]  po_count,
	output logic                                  pi_ready,
	output logic                                  po_ready
);

	// Room for one whole block plus slack for the registered flag
	localparam int PI_LIMIT = FIFO_DEPTH - HEADROOM - BLOCK;

	always_ff @(posedge okClk) begin
		if (rst || soft_rst) begin
			pi_ready <= 1'b0;
			po_ready <= 1'b0;
		end else begin
			// Space for another inbound block
			if (int'(pi_count) <= PI_LIMIT) begin
				pi_ready <= 1'b1;
			end else begin
				pi_ready <= 1'b0;
			end

			// A whole block waiting for the host
			if (int'(po_count) >= BLOCK) begin
				po_ready <= 1'b1;
			end else begin
				po_ready <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/ramtest_top.sv
`timescale 1ns/1ns
`default_nettype none

module ramtest_top
	import ramtest_pkg::*;
#(
	parameter int FIFO_DEPTH = 64,
	parameter int BLOCK      = 16,
	parameter int HEADROOM   = 4,
	parameter int BURST      = 8,
	parameter int MEM_WORDS  = 256,
	parameter int CMD_DEPTH  = 4,
	parameter int READ_LAT   = 3
) (
	input  wire logic              okClk,
	input  wire logic              rst,
	input  wire logic              soft_rst,
	input  wire logic              reads_en,
	input  wire logic              writes_en,
	input  wire logic              pi_write,
	input  wire logic [DATA_W-1:0] pi_data,
	output logic                   pi_ready,
	input  wire logic              po_read,
	output logic      [DATA_W-1:0] po_data,
	output logic                   po_ready
);

	localparam int CNT_W  = $clog2(FIFO_DEPTH+1);
	localparam int ADDR_W = $clog2(MEM_WORDS);

	logic [CNT_W-1:0]  pi_count;
	logic [CNT_W-1:0]  po_count;
	logic              ib_read;
	logic [DATA_W-1:0] ib_data;
	logic              cmd_en;
	mem_op_t           cmd_op;
	logic [ADDR_W-1:0] cmd_addr;
	logic [BL_W-1:0]   cmd_bl;
	logic              cmd_done;
	logic              wr_en;
	logic [DATA_W-1:0] wr_data;
	logic              rd_valid;
	logic [DATA_W-1:0] rd_data;

	// ------------------------------------------------
	// Host pipes and block throttle
	// ------------------------------------------------
	block_fifo #(.DEPTH(FIFO_DEPTH)) pipe_in_fifo (
		.okClk    (okClk),
		.rst      (rst),
		.soft_rst (soft_rst),
		.write    (pi_write),
		.wdata    (pi_data),
		.read     (ib_read),
		.rdata    (ib_data),
		.count    (pi_count),
		.empty    ()
	);

	block_fifo #(.DEPTH(FIFO_DEPTH)) pipe_out_fifo (
		.okClk    (okClk),
		.rst      (rst),
		.soft_rst (soft_rst),
		.write    (rd_valid),  // No full check, DMA output credits cover it
		.wdata    (rd_data),
		.read     (po_read),
		.rdata    (po_data),
		.count    (po_count),
		.empty    ()
	);

	pipe_throttle #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.BLOCK      (BLOCK),
		.HEADROOM   (HEADROOM)
	) throttle (
		.okClk    (okClk),
		.rst      (rst),
		.soft_rst (soft_rst),
		.pi_count (pi_count),
		.po_count (po_count),
		.pi_ready (pi_ready),
		.po_ready (po_ready)
	);

	// ------------------------------------------------
	// DMA and memory
	// ------------------------------------------------
	dma_ctrl #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.BURST      (BURST),
		.MEM_WORDS  (MEM_WORDS),
		.CMD_DEPTH  (CMD_DEPTH)
	) dma (
		.okClk     (okClk),
		.rst       (rst),
		.soft_rst  (soft_rst),
		.reads_en  (reads_en),
		.writes_en (writes_en),
		.ib_count  (pi_count),
		.ib_data   (ib_data),
		.ib_read   (ib_read),
		.po_read   (po_read),
		.cmd_en    (cmd_en),
		.cmd_op    (cmd_op),
		.cmd_addr  (cmd_addr),
		.cmd_bl    (cmd_bl),
		.cmd_done  (cmd_done),
		.wr_en     (wr_en),
		.wr_data   (wr_data)
	);

	mem_port #(
		.BURST     (BURST),
		.MEM_WORDS (MEM_WORDS),
		.CMD_DEPTH (CMD_DEPTH),
		.READ_LAT  (READ_LAT)
	) mem (
		.okClk    (okClk),
		.rst      (rst),
		.soft_rst (soft_rst),
		.cmd_en   (cmd_en),
		.cmd_op   (cmd_op),
		.cmd_addr (cmd_addr),
		.cmd_bl   (cmd_bl),
		.cmd_done (cmd_done),
		.wr_en    (wr_en),
		.wr_data  (wr_data),
		.rd_valid (rd_valid),
		.rd_data  (rd_data)
	);

endmodule

`default_nettype wire

//--- tests/ramtest_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ramtest_tb
	import ramtest_pkg::*;
();

	localparam int FIFO_DEPTH = 64;
	localparam int BLOCK      = 16;
	localparam int HEADROOM   = 4;
	localparam int BURST      = 8;
	localparam int MEM_WORDS  = 256;
	localparam int CMD_DEPTH  = 4;
	localparam int READ_LAT   = 3;
	localparam int N_BLOCKS   = 24 + 4 + 4 + 6; // Blocks written over all phases
	localparam int TIMEOUT    = N_BLOCKS * BLOCK * 40;
	localparam int PI_BLOCKS  = (FIFO_DEPTH - HEADROOM - BLOCK) / BLOCK + 1; // Until pi_ready drops

	logic              okClk;
	logic              rst;
	logic              soft_rst;
	logic              reads_en;
	logic              writes_en;
	logic              pi_write;
	logic [DATA_W-1:0] pi_data;
	logic              pi_ready;
	logic              po_read;
	logic [DATA_W-1:0] po_data;
	logic              po_ready;

	logic [31:0]       lfsr;
	logic [31:0]       model_q [$];  // Words written by the host, oldest first
	int                checks;
	int                errors;
	int                cycles;
	int                blocks;
	logic              got_ready;

	ramtest_top #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.BLOCK      (BLOCK),
		.HEADROOM   (HEADROOM),
		.BURST      (BURST),
		.MEM_WORDS  (MEM_WORDS),
		.CMD_DEPTH  (CMD_DEPTH),
		.READ_LAT   (READ_LAT)
	) uut (
		.okClk     (okClk),
		.rst       (rst),
		.soft_rst  (soft_rst),
		.reads_en  (reads_en),
		.writes_en (writes_en),
		.pi_write  (pi_write),
		.pi_data   (pi_data),
		.pi_ready  (pi_ready),
		.po_read   (po_read),
		.po_data   (po_data),
		.po_ready  (po_ready)
	);

	always #50 okClk = ~okClk;

	// Run limit
	always @(posedge okClk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: traffic did not complete within %0d cycles", TIMEOUT);
			$display("Checks: %0d  Errors: %0d", checks, errors);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]}; // One step per bit
		end
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic note_failure(input string msg);
		errors++;
		$display("Failure at %0t: %s", $time, msg);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge okClk);
	endtask

	task automatic hold_po_low(input int n);
		logic seen;
		seen = 1'b0;
		repeat (n) begin
			@(negedge okClk);
			if (po_ready && !seen) begin
				note_failure("po_ready went high although no data can reach pipe-out");
				seen = 1'b1;
			end
		end
	endtask

	// Nothing may be left in either pipe once every block is read
	task automatic check_drained();
		wait_cycles(2 * BURST);
		compare("po_ready", po_ready, 1'b0);
		compare("pi_ready", pi_ready, 1'b1);
	endtask

	// Host writer and reader, one decision each per cycle
	task automatic traffic(input int wr_blocks, input int rd_blocks);
		int wr_done;
		int rd_done;
		int wr_left;
		int rd_left;
		int wr_idle;
		int rd_idle;
		logic [31:0] r;
		wr_done = 0;
		rd_done = 0;
		wr_left = 0;
		rd_left = 0;
		wr_idle = 1;
		rd_idle = 1;
		while (wr_done < wr_blocks || rd_done < rd_blocks) begin
			@(negedge okClk);
			pi_write = 1'b0;
			po_read  = 1'b0;
			if (wr_left == 0) begin
				if (wr_done < wr_blocks && wr_idle > 0 && pi_ready) begin
					wr_left = BLOCK;
				end else begin
					wr_idle++;
				end
			end
			if (wr_left != 0) begin
				take_bits(2, r);
				if (r[1:0] != 2'b00) begin // Gap one cycle in four
					take_bits(32, r);
					pi_write = 1'b1;
					pi_data  = r;
					model_q.push_back(r);
					wr_left--;
					if (wr_left == 0) begin
						wr_done++;
						wr_idle = 0;
					end
				end
			end
			// Idle cycle before a start, so po_ready has seen the last read
			if (rd_left == 0) begin
				if (rd_done < rd_blocks && rd_idle > 0 && po_ready) begin
					if (model_q.size() < BLOCK) begin
						note_failure("po_ready high with less than a block written and unread");
					end
					rd_left = BLOCK;
				end else begin
					rd_idle++;
				end
			end
			if (rd_left != 0) begin
				take_bits(2, r);
				if (r[1:0] != 2'b00) begin
					po_read = 1'b1;
					if (model_q.size() == 0) begin
						note_failure("host read with no unread word in the model");
					end else begin
						compare("po_data", po_data, model_q.pop_front());
					end
					rd_left--;
					if (rd_left == 0) begin
						rd_done++;
						rd_idle = 0;
					end
				end
			end
		end
		@(negedge okClk);
		pi_write = 1'b0;
		po_read  = 1'b0;
	endtask

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial begin
		okClk      = 1'b0;
		rst        = 1'b1;
		soft_rst   = 1'b0;
		reads_en   = 1'b0;
		writes_en  = 1'b0;
		pi_write   = 1'b0;
		pi_data    = '0;
		po_read    = 1'b0;
		lfsr       = 32'h5c13_2b0c;
		checks     = 0;
		errors     = 0;
		cycles     = 0;
		wait_cycles(16);
		rst = 1'b0;

		// Flags after reset
		got_ready = 1'b0;
		repeat (2) begin
			@(negedge okClk);
			if (pi_ready) got_ready = 1'b1;
		end
		if (!got_ready) note_failure("pi_ready not high within two cycles of reset");
		hold_po_low(20);

		// Mixed loopback
		reads_en  = 1'b1;
		writes_en = 1'b1;
		traffic(24, 24);
		check_drained();

		// Writes held off until the pipe-in throttle closes
		writes_en = 1'b0;
		blocks = 0;
		wait_cycles(2);
		while (pi_ready && blocks < FIFO_DEPTH / BLOCK) begin
			traffic(1, 0);
			blocks++;
			wait_cycles(2); // Count then flag
		end
		if (pi_ready) note_failure("pi_ready stayed high with writes disabled");
		compare("blocks accepted while pi_ready", blocks, PI_BLOCKS);
		hold_po_low(200);
		writes_en = 1'b1;
		traffic(0, blocks);
		check_drained();

		// Reads held off
		reads_en = 1'b0;
		traffic(4, 0);
		hold_po_low(200);
		reads_en = 1'b1;
		traffic(0, 4);
		check_drained();

		// Soft reset with data in flight
		traffic(2, 1);
		wait_cycles(30);
		soft_rst = 1'b1;
		model_q.delete();
		wait_cycles(2);
		soft_rst = 1'b0;
		hold_po_low(10);
		traffic(4, 4);
		check_drained();

		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire
